// ==== hw/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_rob_addr;

// Full LC-3b opcode map, only ADD, AND and NOT are executed
typedef enum logic [3:0]
{
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

localparam int rob_depth = 8;     // Must match the tag width
localparam int num_stations = 3;  // ALU reservation stations

endpackage: lc3b_types

// ==== hw/issue_control.sv ====
`timescale 1ns/1ps

module issue_control import lc3b_types::*;
(
	input logic clk,
	// Instruction source
	input lc3b_word instr,
	input logic instr_is_new,
	output logic issue_ready,
	// Common data bus
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_data,
	// Reservation stations
	input logic [num_stations-1:0] station_busy,
	output logic [num_stations-1:0] res_load,
	output lc3b_opcode res_op,
	output lc3b_word res_vj,
	output lc3b_word res_vk,
	output lc3b_rob_addr res_qj,
	output lc3b_rob_addr res_qk,
	output logic res_valid_j,
	output logic res_valid_k,
	output lc3b_rob_addr res_dest,
	// Reorder buffer
	input logic rob_full,
	input lc3b_rob_addr rob_addr,
	input lc3b_word rob_value_out [rob_depth-1:0],
	input logic rob_valid_out [rob_depth-1:0],
	output logic rob_write_enable,
	output lc3b_reg rob_dest_reg,
	// Register status
	input lc3b_word reg_value [7:0],
	input logic reg_busy [7:0],
	input lc3b_rob_addr reg_robs [7:0],
	output lc3b_reg reg_dest,
	output logic ld_reg_busy_dest,
	output lc3b_rob_addr reg_rob_entry
);

lc3b_opcode opcode;
lc3b_reg dest_reg;
lc3b_reg src_reg [2];      // SR1, SR2
lc3b_word imm5;
logic is_alu;
logic use_imm;
logic accept;
logic do_issue;
logic [num_stations-1:0] free_station;

lc3b_word src_val [2];
lc3b_rob_addr src_tag [2];
logic src_ok [2];

assign opcode = lc3b_opcode'(instr[15:12]);
assign dest_reg = instr[11:9];
assign src_reg[0] = instr[8:6];
assign src_reg[1] = instr[2:0];
assign imm5 = {{11{instr[4]}}, instr[4:0]};

assign is_alu = (opcode == op_add) || (opcode == op_and) || (opcode == op_not);
assign use_imm = instr[5] || (opcode == op_not);   // NOT has no second source

// Stall on a full ROB or when every station is taken
assign issue_ready = !rob_full && !(&station_busy);
assign accept = instr_is_new && issue_ready;
assign do_issue = accept && is_alu;   // Other opcodes are consumed silently

// Lowest zero bit of the busy vector
assign free_station = ~station_busy & (station_busy + 1'b1);

// Operand lookup: register file, then bus, then ROB, else wait on the tag
always_comb
begin
	for (int s = 0; s < 2; s++)
	begin
		src_tag[s] = reg_robs[src_reg[s]];
		if (!reg_busy[src_reg[s]])
		begin
			src_val[s] = reg_value[src_reg[s]];
			src_ok[s] = 1'b1;
		end
		else if (cdb_valid && cdb_tag == src_tag[s])
		begin
			src_val[s] = cdb_data;  // Broadcast in this very cycle
			src_ok[s] = 1'b1;
		end
		else if (rob_valid_out[src_tag[s]])
		begin
			src_val[s] = rob_value_out[src_tag[s]];
			src_ok[s] = 1'b1;
		end
		else
		begin
			src_val[s] = '0;
			src_ok[s] = 1'b0;
		end
	end
end

// Station fields, shared by all stations
assign res_load = do_issue ? free_station : '0;
assign res_op = opcode;
assign res_vj = src_val[0];
assign res_qj = src_tag[0];
assign res_valid_j = src_ok[0];
assign res_vk = use_imm ? imm5 : src_val[1];
assign res_qk = src_tag[1];
assign res_valid_k = use_imm || src_ok[1];
assign res_dest = rob_addr;   // Result tag is the new ROB entry

assign rob_write_enable = do_issue;
assign rob_dest_reg = dest_reg;

// Destination now waits on this ROB entry
assign reg_dest = dest_reg;
assign ld_reg_busy_dest = do_issue;
assign reg_rob_entry = rob_addr;

endmodule: issue_control

// ==== hw/reg_status_file.sv ====
`timescale 1ns/1ps

module reg_status_file import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	// From issue
	input logic ld_reg_busy_dest,
	input lc3b_reg reg_dest,
	input lc3b_rob_addr reg_rob_entry,
	// From ROB commit
	input logic commit_valid,
	input lc3b_reg commit_reg,
	input lc3b_word commit_value,
	input lc3b_rob_addr commit_tag,
	// Status out
	output lc3b_word reg_value [7:0],
	output logic reg_busy [7:0],
	output lc3b_rob_addr reg_robs [7:0]
);

logic clear_busy;

// Only the newest producer frees the register, and a same-edge issue wins
assign clear_busy = commit_valid
	&& (reg_robs[commit_reg] == commit_tag)
	&& !(ld_reg_busy_dest && reg_dest == commit_reg);

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int i = 0; i < 8; i++)
		begin
			reg_value[i] <= '0;
			reg_busy[i] <= 1'b0;
			reg_robs[i] <= '0;
		end
	end
	else
	begin
		if (commit_valid)
			reg_value[commit_reg] <= commit_value;  // Value lands even if renamed again
		if (clear_busy)
			reg_busy[commit_reg] <= 1'b0;
		if (ld_reg_busy_dest)
		begin
			reg_busy[reg_dest] <= 1'b1;
			reg_robs[reg_dest] <= reg_rob_entry;
		end
	end
end

endmodule: reg_status_file

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	// Allocation from issue
	input logic rob_write_enable,
	input lc3b_reg rob_dest_reg,
	// Common data bus
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_data,
	// To issue
	output lc3b_rob_addr rob_addr,
	output logic rob_full,
	output lc3b_word rob_value_out [rob_depth-1:0],
	output logic rob_valid_out [rob_depth-1:0],
	// Commit
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value,
	output lc3b_rob_addr commit_tag
);

lc3b_rob_addr head;
lc3b_rob_addr tail;
logic [$clog2(rob_depth+1)-1:0] count;
lc3b_reg dest_regs [rob_depth-1:0];
logic retire;

assign rob_addr = tail;
assign rob_full = (count == rob_depth);
assign retire = (count != 0) && rob_valid_out[head];   // Head has its result

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		commit_valid <= 1'b0;
		for (int i = 0; i < rob_depth; i++)
			rob_valid_out[i] <= 1'b0;
	end
	else
	begin
		commit_valid <= retire;
		if (retire)
			head <= head + 1'b1;
		// Valid stays set after retire until the register file has the value
		if (rob_write_enable)
		begin
			tail <= tail + 1'b1;
			rob_valid_out[tail] <= 1'b0;
		end
		if (cdb_valid)
			rob_valid_out[cdb_tag] <= 1'b1;
		case ({rob_write_enable, retire})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (rob_write_enable)
		dest_regs[tail] <= rob_dest_reg;
	if (cdb_valid)
		rob_value_out[cdb_tag] <= cdb_data;
	commit_reg <= dest_regs[head];
	commit_value <= rob_value_out[head];
	commit_tag <= head;
end

endmodule: reorder_buffer

// ==== hw/alu_station.sv ====
`timescale 1ns/1ps

module alu_station import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	// Write from issue
	input logic load,
	input lc3b_opcode op_in,
	input lc3b_word vj_in,
	input lc3b_word vk_in,
	input lc3b_rob_addr qj_in,
	input lc3b_rob_addr qk_in,
	input logic valid_j_in,
	input logic valid_k_in,
	input lc3b_rob_addr dest_in,
	// Bus snoop
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input lc3b_word cdb_data,
	// Dispatch
	input logic grant,
	output logic busy,
	output logic ready,
	output lc3b_opcode op,
	output lc3b_word vj,
	output lc3b_word vk,
	output lc3b_rob_addr dest
);

lc3b_rob_addr qj;
lc3b_rob_addr qk;
logic valid_j;
logic valid_k;
logic snoop_j;
logic snoop_k;

// Pending operand matches the broadcast tag
assign snoop_j = busy && !valid_j && cdb_valid && (cdb_tag == qj);
assign snoop_k = busy && !valid_k && cdb_valid && (cdb_tag == qk);

assign ready = busy && valid_j && valid_k;

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		busy <= 1'b0;
		valid_j <= 1'b0;
		valid_k <= 1'b0;
	end
	else if (load)
	begin
		busy <= 1'b1;
		valid_j <= valid_j_in;
		valid_k <= valid_k_in;
	end
	else if (grant)
		busy <= 1'b0;   // Handed to the execute unit
	else
	begin
		if (snoop_j)
			valid_j <= 1'b1;
		if (snoop_k)
			valid_k <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (load)
	begin
		op <= op_in;
		vj <= vj_in;
		vk <= vk_in;
		qj <= qj_in;
		qk <= qk_in;
		dest <= dest_in;
	end
	else
	begin
		if (snoop_j)
			vj <= cdb_data;
		if (snoop_k)
			vk <= cdb_data;
	end
end

endmodule: alu_station

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	// From stations
	input logic [num_stations-1:0] station_ready,
	input lc3b_opcode station_op [num_stations-1:0],
	input lc3b_word station_vj [num_stations-1:0],
	input lc3b_word station_vk [num_stations-1:0],
	input lc3b_rob_addr station_dest [num_stations-1:0],
	output logic [num_stations-1:0] grant,
	// Common data bus
	output logic cdb_valid,
	output lc3b_rob_addr cdb_tag,
	output lc3b_word cdb_data
);

lc3b_opcode sel_op;
lc3b_word sel_vj;
lc3b_word sel_vk;
lc3b_rob_addr sel_dest;
lc3b_word result;

// Fixed priority, lowest ready station
assign grant = station_ready & ~(station_ready - 1'b1);

always_comb
begin
	sel_op = station_op[0];
	sel_vj = station_vj[0];
	sel_vk = station_vk[0];
	sel_dest = station_dest[0];
	for (int i = 1; i < num_stations; i++)
	begin
		if (grant[i])
		begin
			sel_op = station_op[i];
			sel_vj = station_vj[i];
			sel_vk = station_vk[i];
			sel_dest = station_dest[i];
		end
	end
end

always_comb
begin
	case (sel_op)
		op_add: result = sel_vj + sel_vk;
		op_and: result = sel_vj & sel_vk;
		op_not: result = ~sel_vj;
		default: result = '0;
	endcase
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		cdb_valid <= 1'b0;
	else
		cdb_valid <= |station_ready;  // One broadcast per cycle
end

always_ff @(posedge clk)
begin
	if (|station_ready)
	begin
		cdb_tag <= sel_dest;
		cdb_data <= result;
	end
end

endmodule: execute_unit

// ==== hw/tomasulo_core.sv ====
`timescale 1ns/1ps

module tomasulo_core import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	input lc3b_word instr,
	input logic instr_is_new,
	output logic issue_ready,
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value
);

// Issue to stations
logic [num_stations-1:0] res_load;
lc3b_opcode res_op;
lc3b_word res_vj;
lc3b_word res_vk;
lc3b_rob_addr res_qj;
lc3b_rob_addr res_qk;
logic res_valid_j;
logic res_valid_k;
lc3b_rob_addr res_dest;

// Stations to execute
logic [num_stations-1:0] station_busy;
logic [num_stations-1:0] station_ready;
logic [num_stations-1:0] grant;
lc3b_opcode station_op [num_stations-1:0];
lc3b_word station_vj [num_stations-1:0];
lc3b_word station_vk [num_stations-1:0];
lc3b_rob_addr station_dest [num_stations-1:0];

logic cdb_valid;
lc3b_rob_addr cdb_tag;
lc3b_word cdb_data;

logic rob_write_enable;
lc3b_reg rob_dest_reg;
lc3b_rob_addr rob_addr;
logic rob_full;
lc3b_word rob_value_out [rob_depth-1:0];
logic rob_valid_out [rob_depth-1:0];
lc3b_rob_addr commit_tag;

lc3b_reg reg_dest;
logic ld_reg_busy_dest;
lc3b_rob_addr reg_rob_entry;
lc3b_word reg_value [7:0];
logic reg_busy [7:0];
lc3b_rob_addr reg_robs [7:0];

issue_control issue_control_i
(
	.clk(clk),
	.instr(instr),
	.instr_is_new(instr_is_new),
	.issue_ready(issue_ready),
	.cdb_valid(cdb_valid),
	.cdb_tag(cdb_tag),
	.cdb_data(cdb_data),
	.station_busy(station_busy),
	.res_load(res_load),
	.res_op(res_op),
	.res_vj(res_vj),
	.res_vk(res_vk),
	.res_qj(res_qj),
	.res_qk(res_qk),
	.res_valid_j(res_valid_j),
	.res_valid_k(res_valid_k),
	.res_dest(res_dest),
	.rob_full(rob_full),
	.rob_addr(rob_addr),
	.rob_value_out(rob_value_out),
	.rob_valid_out(rob_valid_out),
	.rob_write_enable(rob_write_enable),
	.rob_dest_reg(rob_dest_reg),
	.reg_value(reg_value),
	.reg_busy(reg_busy),
	.reg_robs(reg_robs),
	.reg_dest(reg_dest),
	.ld_reg_busy_dest(ld_reg_busy_dest),
	.reg_rob_entry(reg_rob_entry)
);

reg_status_file reg_status_file_i
(
	.clk(clk),
	.arst_n(arst_n),
	.ld_reg_busy_dest(ld_reg_busy_dest),
	.reg_dest(reg_dest),
	.reg_rob_entry(reg_rob_entry),
	.commit_valid(commit_valid),
	.commit_reg(commit_reg),
	.commit_value(commit_value),
	.commit_tag(commit_tag),
	.reg_value(reg_value),
	.reg_busy(reg_busy),
	.reg_robs(reg_robs)
);

reorder_buffer reorder_buffer_i
(
	.clk(clk),
	.arst_n(arst_n),
	.rob_write_enable(rob_write_enable),
	.rob_dest_reg(rob_dest_reg),
	.cdb_valid(cdb_valid),
	.cdb_tag(cdb_tag),
	.cdb_data(cdb_data),
	.rob_addr(rob_addr),
	.rob_full(rob_full),
	.rob_value_out(rob_value_out),
	.rob_valid_out(rob_valid_out),
	.commit_valid(commit_valid),
	.commit_reg(commit_reg),
	.commit_value(commit_value),
	.commit_tag(commit_tag)
);

// All stations see the same issue fields, res_load picks one
for (genvar g = 0; g < num_stations; g++)
begin: gen_station
	alu_station alu_station_i
	(
		.clk(clk),
		.arst_n(arst_n),
		.load(res_load[g]),
		.op_in(res_op),
		.vj_in(res_vj),
		.vk_in(res_vk),
		.qj_in(res_qj),
		.qk_in(res_qk),
		.valid_j_in(res_valid_j),
		.valid_k_in(res_valid_k),
		.dest_in(res_dest),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.grant(grant[g]),
		.busy(station_busy[g]),
		.ready(station_ready[g]),
		.op(station_op[g]),
		.vj(station_vj[g]),
		.vk(station_vk[g]),
		.dest(station_dest[g])
	);
end

execute_unit execute_unit_i
(
	.clk(clk),
	.arst_n(arst_n),
	.station_ready(station_ready),
	.station_op(station_op),
	.station_vj(station_vj),
	.station_vk(station_vk),
	.station_dest(station_dest),
	.grant(grant),
	.cdb_valid(cdb_valid),
	.cdb_tag(cdb_tag),
	.cdb_data(cdb_data)
);

endmodule: tomasulo_core

// ==== bench/tb_tomasulo_core.sv ====
`timescale 1ns/1ps

module tb_tomasulo_core import lc3b_types::*;
();

localparam int max_tests = 16;
localparam int burst_test = 5;     // Sent back to back
localparam int ready_limit = 100;  // Cycles
localparam int commit_limit = 100;

logic clk;
logic arst_n;
lc3b_word instr;
logic instr_is_new;
logic issue_ready;
logic commit_valid;
lc3b_reg commit_reg;
lc3b_word commit_value;

// Program and expected commits, in file order
lc3b_word prog_word [$];
int prog_test [$];
int exp_test [$];
lc3b_reg exp_reg [$];
lc3b_word exp_val [$];

int expect_count [max_tests];
int done_count [max_tests];
int test_errors [max_tests];
int stall_count [max_tests];
bit finished [max_tests];

int check_count = 0;
int error_count = 0;
int tests_passed = 0;
int tests_failed = 0;
bit program_ok = 1'b1;
bit aborted = 1'b0;
int unsigned rand_state;

tomasulo_core dut_i
(
	.clk(clk),
	.arst_n(arst_n),
	.instr(instr),
	.instr_is_new(instr_is_new),
	.issue_ready(issue_ready),
	.commit_valid(commit_valid),
	.commit_reg(commit_reg),
	.commit_value(commit_value)
);

always #20 clk = ~clk;

function automatic int unsigned next_random();
	rand_state = rand_state * 32'd1103515245 + 32'd12345;
	return rand_state >> 16;
endfunction

function automatic string test_name(input int t);
	case (t)
		1: return "reset state";
		2: return "immediate add";
		3: return "register ops";
		4: return "dependent chains";
		5: return "stall burst";
		6: return "dropped opcodes";
		default: return "unnamed";
	endcase
endfunction

// Only these three reach the ROB
function automatic bit is_alu_op(input lc3b_word w);
	return (w[15:12] == op_add) || (w[15:12] == op_and) || (w[15:12] == op_not);
endfunction

task automatic compare_values(input int t, input string what, input logic [15:0] expected,
	input logic [15:0] actual);
	check_count++;
	if (actual !== expected)
	begin
		error_count++;
		test_errors[t]++;
		$display("Error in test %0d %s, %s: expected %h, actual %h",
			t, test_name(t), what, expected, actual);
	end
endtask

task automatic finish_test(input int t);
	if (t == burst_test && stall_count[t] == 0)
	begin
		error_count++;
		test_errors[t]++;
		$display("Test %0d %s: issue_ready never dropped during the burst", t, test_name(t));
	end
	finished[t] = 1'b1;
	if (test_errors[t] == 0)
	begin
		tests_passed++;
		$display("Test %0d %s: passed, %0d commits", t, test_name(t), done_count[t]);
	end
	else
	begin
		tests_failed++;
		$display("Test %0d %s: failed with %0d errors", t, test_name(t), test_errors[t]);
	end
endtask

task automatic load_program();
	int fd;
	int fields;
	string line;
	lc3b_word word;
	int test_id;
	int reg_num;
	lc3b_word value;
	fd = $fopen("bench/program_input.txt", "r");
	if (fd == 0)
	begin
		$display("Could not open bench/program_input.txt");
		program_ok = 1'b0;
		return;
	end
	while (!$feof(fd))
	begin
		line = "";
		fields = $fgets(line, fd);
		if (fields > 0 && line.len() > 1 && line.getc(0) != "#")
		begin
			fields = $sscanf(line, "%h %d %d %h", word, test_id, reg_num, value);
			if (fields == 4 && test_id > 1 && test_id < max_tests)
			begin
				prog_word.push_back(word);
				prog_test.push_back(test_id);
				if (is_alu_op(word))
				begin
					exp_test.push_back(test_id);
					exp_reg.push_back(lc3b_reg'(reg_num));
					exp_val.push_back(value);
					expect_count[test_id]++;
				end
			end
			else
			begin
				$display("The program file has a line that cannot be read: %s", line);
				program_ok = 1'b0;
			end
		end
	end
	$fclose(fd);
	if (prog_word.size() == 0)
	begin
		$display("The program file holds no instructions");
		program_ok = 1'b0;
	end
endtask

// Nothing may commit while the core sits idle
task automatic check_reset_state();
	repeat (3)
	begin
		@(negedge clk);
		compare_values(1, "issue_ready", 16'd1, issue_ready);
		compare_values(1, "commit_valid", 16'd0, commit_valid);
	end
	finish_test(1);
endtask

// Called at posedge + 2 ns, returns at posedge + 2 ns after the transfer
task automatic send_instruction(input int idx);
	int waited;
	bit taken;
	waited = 0;
	taken = 1'b0;
	instr = prog_word[idx];
	instr_is_new = 1'b1;
	while (!taken && waited < ready_limit && !aborted)
	begin
		@(negedge clk);
		taken = issue_ready;   // Stable mid-cycle
		if (!taken)
			stall_count[prog_test[idx]]++;
		@(posedge clk);
		#2;
		waited++;
	end
	instr_is_new = 1'b0;
	if (!taken && !aborted)
	begin
		$display("Timeout: issue_ready stayed low for %0d cycles at program line %0d",
			ready_limit, idx + 1);
		aborted = 1'b1;
	end
endtask

task automatic drive_program();
	int gap;
	for (int i = 0; i < prog_word.size(); i++)
	begin
		if (aborted)
			break;
		gap = (prog_test[i] == burst_test) ? 0 : int'(next_random() % 4);
		repeat (gap)
		begin
			@(posedge clk);
			#2;
		end
		send_instruction(i);
	end
endtask

task automatic check_commits();
	int waited;
	bit seen;
	int t;
	lc3b_reg r;
	lc3b_word v;
	while (exp_test.size() > 0 && !aborted)
	begin
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < commit_limit && !aborted)
		begin
			@(negedge clk);
			seen = commit_valid;
			waited++;
		end
		if (!seen)
		begin
			if (!aborted)
				$display("Timeout: no commit within %0d cycles while test %0d waits for one",
					commit_limit, exp_test[0]);
			aborted = 1'b1;
		end
		else
		begin
			t = exp_test.pop_front();
			r = exp_reg.pop_front();
			v = exp_val.pop_front();
			compare_values(t, $sformatf("commit %0d register", done_count[t] + 1), r, commit_reg);
			compare_values(t, $sformatf("commit %0d value", done_count[t] + 1), v, commit_value);
			done_count[t]++;
			if (done_count[t] == expect_count[t])
				finish_test(t);
		end
	end
	// Dropped opcodes must not sneak in a late commit
	if (!aborted)
	begin
		repeat (20)
		begin
			@(negedge clk);
			if (commit_valid)
			begin
				error_count++;
				$display("A commit to R%0d arrived after the last expected one", commit_reg);
			end
		end
	end
endtask

initial
begin
	clk = 1'b0;
	arst_n = 1'b0;
	instr = '0;
	instr_is_new = 1'b0;
	rand_state = 72246;
	load_program();
	if (program_ok)
	begin
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;
		check_reset_state();
		@(posedge clk);
		#2;
		fork
			drive_program();
			check_commits();
		join
	end
	for (int t = 2; t < max_tests; t++)
	begin
		if (expect_count[t] > 0 && !finished[t])
		begin
			tests_failed++;
			$display("Test %0d %s: did not finish", t, test_name(t));
		end
	end
	$display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
		tests_passed, tests_failed, check_count, error_count);
	if (program_ok && !aborted && error_count == 0 && tests_failed == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule: tb_tomasulo_core

// ==== list.f ====
hw/lc3b_types.sv
hw/issue_control.sv
hw/reg_status_file.sv
hw/reorder_buffer.sv
hw/alu_station.sv
hw/execute_unit.sv
hw/tomasulo_core.sv
bench/tb_tomasulo_core.sv

// ==== Bender.yml ====
package:
  name: tomasulo_core

sources:
  - hw/lc3b_types.sv
  - hw/issue_control.sv
  - hw/reg_status_file.sv
  - hw/reorder_buffer.sv
  - hw/alu_station.sv
  - hw/execute_unit.sv
  - hw/tomasulo_core.sv
  - target: test
    files:
      - bench/tb_tomasulo_core.sv

// ==== bench/program_input.txt ====
# instr(hex) test expected_reg expected_value(hex)
# reg and value are ignored for opcodes other than ADD, AND and NOT
1225 2 1 0005
143D 2 2 FFFD
162F 2 3 000F
1830 2 4 FFF0
1A29 2 5 0009
1C43 3 6 0014
5E84 3 7 FFF0
9D7F 3 6 FFF6
5A43 3 5 0005
1881 3 4 0002
1241 4 1 000A
1263 4 1 000D
5443 4 2 000D
96BF 4 3 FFF2
18C1 4 4 FFFF
5B27 4 5 0007
1D45 4 6 000E
1FE1 5 7 FFF1
1FE1 5 7 FFF2
1FE1 5 7 FFF3
1FE1 5 7 FFF4
13C1 5 1 0001
1FE1 5 7 FFF5
1FE1 5 7 FFF6
55C1 5 2 0000
96BF 5 3 FFFF
18E2 5 4 0001
0000 6 0 0000
1B46 6 5 0015
2A40 6 0 0000
5D43 6 6 0015
C1C0 6 0 0000
93BF 6 1 FFEA
F025 6 0 0000
1461 6 2 FFEB
